// ==== tb.f ====
sprite_pkg.sv
sprite_fetch_if.sv
sprite_rom_bank.sv
sprite_compositor.sv
fighter_render_top.sv
tb_render_assertions.sv
tb_pixel_checker.sv
tb_fighter_render.sv

// ==== tb_fighter_render.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fighter_render;
    import sprite_pkg::*;

    localparam int NUM_ROWS       = 24;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS + 50;

    // One pixel request with its scene
    typedef struct {
        int id;
        int px;
        int py;
        int px2;
        int py2;
        int p1;
        int p2;
        int x;
        int y;
        bit stall;                          // Random out_ready while this row runs
    } stim_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    logic [COORD_W-1:0] in_x;
    logic [COORD_W-1:0] in_y;
    logic [COORD_W-1:0] posx;
    logic [COORD_W-1:0] posy;
    logic [COORD_W-1:0] posx2;
    logic [COORD_W-1:0] posy2;
    logic [POSE_W-1:0]  pose;
    logic [POSE_W-1:0]  pose2;
    logic               out_valid;
    logic               out_ready   = 1'b1;
    logic               out_visible;
    logic [2:0]         out_red;
    logic [2:0]         out_green;
    logic [1:0]         out_blue;
    logic [7:0]         test_id;
    logic               stall_en;
    logic [31:0]        rng_state   = 32'd71717;
    int                 cycle_count = 0;
    int                 outputs_seen;
    int                 error_count;
    int                 tests_passed;
    int                 tests_failed;
    stim_t              rows [NUM_ROWS];

    always #4 clk = ~clk;                   // 8 ns period

    fighter_render_top u_dut (
        .clk (clk), .rst (rst),
        .in_valid (in_valid), .in_ready (in_ready), .in_x (in_x), .in_y (in_y),
        .posx (posx), .posy (posy), .posx2 (posx2), .posy2 (posy2),
        .pose (pose), .pose2 (pose2),
        .out_valid (out_valid), .out_ready (out_ready), .out_visible (out_visible),
        .out_red (out_red), .out_green (out_green), .out_blue (out_blue)
    );

    tb_pixel_checker u_checker (
        .clk (clk), .rst (rst), .test_id (test_id),
        .in_valid (in_valid), .in_ready (in_ready), .in_x (in_x), .in_y (in_y),
        .posx (posx), .posy (posy), .posx2 (posx2), .posy2 (posy2),
        .pose (pose), .pose2 (pose2),
        .out_valid (out_valid), .out_ready (out_ready), .out_visible (out_visible),
        .out_red (out_red), .out_green (out_green), .out_blue (out_blue),
        .outputs_seen (outputs_seen), .error_count (error_count),
        .tests_passed (tests_passed), .tests_failed (tests_failed)
    );

    bind sprite_compositor tb_render_assertions u_assertions (
        .clk (clk), .rst (rst), .out_valid (out_valid), .out_ready (out_ready),
        .out_visible (out_visible), .out_color (out_color)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic set_row(input int id, input int px, input int py, input int px2,
                           input int py2, input int p1, input int p2, input int x,
                           input int y, input bit stall);
        rows[id-1] = '{id, px, py, px2, py2, p1, p2, x, y, stall};
    endtask

    task automatic drive_row(input int i);
        in_valid <= 1'b1;
        test_id  <= 8'(rows[i].id);
        posx     <= COORD_W'(rows[i].px);
        posy     <= COORD_W'(rows[i].py);
        posx2    <= COORD_W'(rows[i].px2);
        posy2    <= COORD_W'(rows[i].py2);
        pose     <= POSE_W'(rows[i].p1);
        pose2    <= POSE_W'(rows[i].p2);
        in_x     <= COORD_W'(rows[i].x);
        in_y     <= COORD_W'(rows[i].y);
        stall_en <= rows[i].stall;
    endtask

    // Returns after the edge that took the request
    task automatic wait_accept();
        @(posedge clk);
        while (!in_ready) @(posedge clk);
    endtask

    // Back-pressure, about three ready cycles in four
    always @(negedge clk) begin
        if (stall_en) begin
            rng_state = xorshift32(rng_state);
            out_ready <= rng_state[0] | rng_state[5];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Watchdog
    always @(negedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d outputs received",
                     cycle_count, outputs_seen, NUM_ROWS);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst      <= 1'b1;                   // Edge lands once every process waits on it
        in_valid = 1'b0;
        in_x     = '0;
        in_y     = '0;
        posx     = '0;
        posy     = '0;
        posx2    = '0;
        posy2    = '0;
        pose     = '0;
        pose2    = '0;
        test_id  = '0;
        stall_en = 1'b0;

        //      id  px    py    px2  py2  p1  p2  x     y     stall
        set_row( 1, 100,  50,   600, 400, 0,  0,  101,  50,   0);  // Player 1 alone
        set_row( 2, 100,  50,   600, 400, 3,  0,  100,  50,   0);
        set_row( 3, 100,  50,   600, 400, 5,  0,  114,  65,   0);
        set_row( 4, 100,  50,   600, 400, 9,  0,  107,  52,   0);
        set_row( 5, 0,    0,    300, 200, 0,  10, 306,  201,  0);  // Player 2 alone
        set_row( 6, 0,    0,    300, 200, 0,  10, 305,  201,  0);
        set_row( 7, 0,    0,    300, 200, 0,  1,  300,  215,  0);
        set_row( 8, 0,    0,    300, 200, 0,  7,  312,  208,  0);
        set_row( 9, 0,    0,    300, 200, 0,  2,  311,  204,  0);
        set_row(10, 400,  300,  409, 304, 1,  4,  412,  305,  0);  // Overlap
        set_row(11, 400,  300,  409, 304, 1,  4,  410,  305,  0);
        set_row(12, 400,  300,  409, 304, 1,  12, 410,  305,  0);
        set_row(13, 400,  300,  409, 304, 6,  3,  409,  304,  0);
        set_row(14, 100,  50,   600, 400, 0,  0,  116,  55,   0);  // Just outside
        set_row(15, 100,  50,   600, 400, 0,  0,  105,  49,   0);
        set_row(16, 0,    0,    300, 200, 0,  0,  316,  205,  0);
        set_row(17, 100,  50,   600, 400, 12, 0,  101,  50,   0);
        set_row(18, 1010, 1015, 600, 400, 8,  0,  1023, 1017, 0);  // Raster edge
        set_row(19, 1010, 1015, 600, 400, 8,  0,  5,    1017, 0);
        set_row(20, 100,  50,   600, 400, 4,  0,  102,  51,   1);  // Under stalls
        set_row(21, 100,  50,   600, 400, 4,  0,  103,  53,   1);
        set_row(22, 400,  300,  409, 304, 6,  8,  412,  307,  1);
        set_row(23, 400,  300,  409, 304, 6,  8,  413,  306,  1);
        set_row(24, 0,    0,    300, 200, 0,  10, 314,  200,  1);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        repeat (3) @(negedge clk);          // Idle window, out_valid must stay low

        for (int i = 0; i < NUM_ROWS; i++) begin
            drive_row(i);
            wait_accept();
            @(negedge clk);
        end
        in_valid <= 1'b0;

        while (outputs_seen < NUM_ROWS) @(negedge clk);
        repeat (4) @(negedge clk);          // Room for a stray extra output

        $display("summary: %0d rows, %0d ok, %0d mismatched, %0d errors, %0d assertion errors",
                 NUM_ROWS, tests_passed, tests_failed, error_count,
                 u_dut.u_compositor.u_assertions.fail_count);
        if (error_count == 0 && tests_failed == 0 && outputs_seen == NUM_ROWS &&
                u_dut.u_compositor.u_assertions.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_pixel_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

// Scoreboard, rebuilds each pixel from the art and priority rules
module tb_pixel_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [7:0]                     test_id,   // Id of the row on the input
    input  logic                           in_valid,
    input  logic                           in_ready,
    input  logic [sprite_pkg::COORD_W-1:0] in_x,
    input  logic [sprite_pkg::COORD_W-1:0] in_y,
    input  logic [sprite_pkg::COORD_W-1:0] posx,
    input  logic [sprite_pkg::COORD_W-1:0] posy,
    input  logic [sprite_pkg::COORD_W-1:0] posx2,
    input  logic [sprite_pkg::COORD_W-1:0] posy2,
    input  logic [sprite_pkg::POSE_W-1:0]  pose,
    input  logic [sprite_pkg::POSE_W-1:0]  pose2,
    input  logic                           out_valid,
    input  logic                           out_ready,
    input  logic                           out_visible,
    input  logic [2:0]                     out_red,
    input  logic [2:0]                     out_green,
    input  logic [1:0]                     out_blue,
    output int                             outputs_seen,
    output int                             error_count,
    output int                             tests_passed,
    output int                             tests_failed
);
    import sprite_pkg::*;

    int         q_id [$];                  // Accepted requests, oldest first
    int         q_x [$];
    int         q_y [$];
    logic [8:0] q_exp [$];                 // {visible, colour}
    int         cur_id;
    logic [8:0] exp_pix;
    logic [7:0] got_color;
    bit         row_ok;
    logic       took_last;                 // Request accepted on the previous edge
    logic       exp_ready;

    // Art rule: diagonal holes, else player, pose, column tint
    function automatic logic [7:0] art_byte(input logic player, input int p,
                                            input int row, input int col);
        if (p >= POSE_COUNT) begin
            return TRANSPARENT_KEY;        // Unused pose codes
        end
        if ((row % 4) == (col % 4)) begin
            return TRANSPARENT_KEY;
        end
        return {player, 4'(p), 3'(col % 8)};
    endfunction

    // Plain integer box test, no wraparound possible
    function automatic bit in_box(input int x, input int y, input int px, input int py);
        return (x >= px) && (x < px + SPRITE_W) && (y >= py) && (y < py + SPRITE_H);
    endfunction

    function automatic logic [8:0] expected_pixel(input int x, input int y,
                                                  input int px, input int py,
                                                  input int px2, input int py2,
                                                  input int p1, input int p2);
        logic [7:0] c1;
        logic [7:0] c2;
        c1 = art_byte(1'b0, p1, y - py, x - px);
        c2 = art_byte(1'b1, p2, y - py2, x - px2);
        if (in_box(x, y, px2, py2) && c2 != TRANSPARENT_KEY) begin
            return {1'b1, c2};             // Player 2 drawn in front
        end
        if (in_box(x, y, px, py) && c1 != TRANSPARENT_KEY) begin
            return {1'b1, c1};
        end
        return {1'b0, BACKGROUND_COLOR};
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            q_id.delete();
            q_x.delete();
            q_y.delete();
            q_exp.delete();
            outputs_seen = 0;
            error_count  = 0;
            tests_passed = 0;
            tests_failed = 0;
            took_last    = 1'b0;
        end else begin
            // Output slot is busy only when an older item than last edge's is in flight
            exp_ready = out_ready || (q_id.size() == 0) || (q_id.size() == 1 && took_last);
            if (in_ready !== exp_ready) begin
                $display("** Error at %0t: in_ready %b, expected %b",
                         $time, in_ready, exp_ready);
                error_count++;
            end
            if (out_valid && q_id.size() == 0) begin
                $display("extra output: out_valid high at %0t with no request pending", $time);
                error_count++;
            end else if (out_valid && out_ready) begin
                cur_id    = q_id.pop_front();
                exp_pix   = q_exp.pop_front();
                got_color = {out_red, out_green, out_blue};
                row_ok    = 1'b1;
                if (out_visible !== exp_pix[8]) begin
                    $display("** Error at %0t: test %0d visible %b, expected %b",
                             $time, cur_id, out_visible, exp_pix[8]);
                    error_count++;
                    row_ok = 1'b0;
                end
                if (got_color !== exp_pix[7:0]) begin
                    $display("** Error at %0t: test %0d colour %02h, expected %02h",
                             $time, cur_id, got_color, exp_pix[7:0]);
                    error_count++;
                    row_ok = 1'b0;
                end
                $display("test %2d  x=%0d y=%0d  visible %b colour %02h  %s",
                         cur_id, q_x.pop_front(), q_y.pop_front(), out_visible,
                         got_color, row_ok ? "ok" : "MISMATCH");
                if (row_ok) tests_passed++;
                else tests_failed++;
                outputs_seen++;
            end
            if (in_valid && in_ready) begin     // Expected value fixed at acceptance
                q_id.push_back(int'(test_id));
                q_x.push_back(int'(in_x));
                q_y.push_back(int'(in_y));
                q_exp.push_back(expected_pixel(in_x, in_y, posx, posy, posx2, posy2,
                                               pose, pose2));
            end
            took_last = in_valid && in_ready;
        end
    end

endmodule

`default_nettype wire

// ==== tb_render_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

// Output handshake properties, bound into the compositor
module tb_render_assertions (
    input logic       clk,
    input logic       rst,
    input logic       out_valid,
    input logic       out_ready,
    input logic       out_visible,
    input logic [7:0] out_color      // Raw RGB332 byte
);
    import sprite_pkg::*;

    int fail_count = 0;              // Failed assertion attempts, read by the testbench top

    // Stalled output keeps valid and payload
    property hold_while_stalled;
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_visible) && $stable(out_color));
    endproperty

    // Visible pixel never carries the key
    property visible_not_key;
        @(posedge clk) disable iff (rst)
        (out_valid && out_visible) |-> (out_color != TRANSPARENT_KEY);
    endproperty

    // No output while reset is applied
    property idle_in_reset;
        @(posedge clk) rst |-> !out_valid;
    endproperty

    assert property (hold_while_stalled) else begin
        $error("output changed while stalled");
        fail_count++;
    end
    assert property (visible_not_key) else begin
        $error("visible pixel carries the key colour");
        fail_count++;
    end
    assert property (idle_in_reset) else begin
        $error("out_valid high during reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== fighter_render_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Sprite pixel stage for the two fighters, plain ports toward the raster side
module fighter_render_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,    // Pixel request from the raster
    output logic                           in_ready,
    input  logic [sprite_pkg::COORD_W-1:0] in_x,        // Requested column
    input  logic [sprite_pkg::COORD_W-1:0] in_y,        // Requested row
    input  logic [sprite_pkg::COORD_W-1:0] posx,        // Fighter 1 position
    input  logic [sprite_pkg::COORD_W-1:0] posy,
    input  logic [sprite_pkg::COORD_W-1:0] posx2,       // Fighter 2 position
    input  logic [sprite_pkg::COORD_W-1:0] posy2,
    input  logic [sprite_pkg::POSE_W-1:0]  pose,        // Fighter 1 pose code
    input  logic [sprite_pkg::POSE_W-1:0]  pose2,       // Fighter 2 pose code
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic                           out_visible, // Sprite pixel, not background
    output logic [2:0]                     out_red,
    output logic [2:0]                     out_green,
    output logic [1:0]                     out_blue
);
    import sprite_pkg::*;

    pixel_t out_color;                                  // Composed RGB332 word

    sprite_compositor u_compositor (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_x        (in_x),
        .in_y        (in_y),
        .posx        (posx),
        .posy        (posy),
        .posx2       (posx2),
        .posy2       (posy2),
        .pose        (pose),
        .pose2       (pose2),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_visible (out_visible),
        .out_color   (out_color)
    );

    // Field view of the union, no extra register stage
    assign out_red   = out_color.rgb.red;
    assign out_green = out_color.rgb.green;
    assign out_blue  = out_color.rgb.blue;

endmodule

`default_nettype wire

// ==== sprite_compositor.sv ====
`timescale 1ns/10ps
`default_nettype none

// Two-stage sprite pixel pipeline with valid/ready on both sides
//   Stage 1 hit flags + ROM read data
//   Stage 2 composed pixel, player 2 in front
module sprite_compositor (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,   // Coordinate request
    output logic                           in_ready,
    input  logic [sprite_pkg::COORD_W-1:0] in_x,
    input  logic [sprite_pkg::COORD_W-1:0] in_y,
    input  logic [sprite_pkg::COORD_W-1:0] posx,       // Fighter 1 top-left
    input  logic [sprite_pkg::COORD_W-1:0] posy,
    input  logic [sprite_pkg::COORD_W-1:0] posx2,      // Fighter 2 top-left
    input  logic [sprite_pkg::COORD_W-1:0] posy2,
    input  logic [sprite_pkg::POSE_W-1:0]  pose,       // Fighter 1 pose
    input  logic [sprite_pkg::POSE_W-1:0]  pose2,      // Fighter 2 pose
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic                           out_visible, // Some sprite is opaque here
    output sprite_pkg::pixel_t             out_color
);
    import sprite_pkg::*;

    // Box test in one extra bit so pos + 16 cannot wrap at the raster edge
    function automatic logic sprite_hit(
        input logic [COORD_W-1:0] x,
        input logic [COORD_W-1:0] y,
        input logic [COORD_W-1:0] px,
        input logic [COORD_W-1:0] py
    );
        logic hit_x;
        logic hit_y;
        hit_x = ({1'b0, x} >= {1'b0, px}) &&
                ({1'b0, x} <  {1'b0, px} + (COORD_W+1)'(SPRITE_W));
        hit_y = ({1'b0, y} >= {1'b0, py}) &&
                ({1'b0, y} <  {1'b0, py} + (COORD_W+1)'(SPRITE_H));
        return hit_x && hit_y;
    endfunction

    // Relative y * 16 + relative x, only meaningful on a hit
    function automatic logic [ADDR_W-1:0] sprite_addr(
        input logic [COORD_W-1:0] x,
        input logic [COORD_W-1:0] y,
        input logic [COORD_W-1:0] px,
        input logic [COORD_W-1:0] py
    );
        logic [COORD_W-1:0] rel_x;
        logic [COORD_W-1:0] rel_y;
        rel_x = x - px;
        rel_y = y - py;
        return {rel_y[ADDR_W/2-1:0], rel_x[ADDR_W/2-1:0]};
    endfunction

    sprite_fetch_if fetch1 ();                  // Fighter 1 bank port
    sprite_fetch_if fetch2 ();                  // Fighter 2 bank port

    logic   advance;                            // Whole pipe shifts this edge
    logic   accept;                             // Input transfer
    logic   hit1;                               // Request inside fighter 1 box
    logic   hit2;                               // Request inside fighter 2 box
    logic   s1_valid;
    logic   s1_hit1;
    logic   s1_hit2;
    logic   opaque1;                            // Fighter 1 covers the pixel
    logic   opaque2;                            // Fighter 2 covers the pixel
    logic   s2_valid;
    logic   s2_visible;
    pixel_t s2_color;

    // Flow control
    assign advance  = !s2_valid || out_ready;   // Output slot free or leaving
    assign in_ready = advance;
    assign accept   = in_valid && in_ready;

    // Request side, hit tests and ROM addresses
    assign hit1 = sprite_hit(in_x, in_y, posx, posy);
    assign hit2 = sprite_hit(in_x, in_y, posx2, posy2);

    assign fetch1.en   = accept;                // ROM data lines up with stage 1
    assign fetch1.pose = pose;
    assign fetch1.addr = sprite_addr(in_x, in_y, posx, posy);
    assign fetch2.en   = accept;
    assign fetch2.pose = pose2;
    assign fetch2.addr = sprite_addr(in_x, in_y, posx2, posy2);

    sprite_rom_bank #(
        .PLAYER (0)
    ) u_rom_p1 (
        .clk   (clk),
        .fetch (fetch1.rom)
    );

    sprite_rom_bank #(
        .PLAYER (1)
    ) u_rom_p2 (
        .clk   (clk),
        .fetch (fetch2.rom)
    );

    // Stage 1, ROM outputs sit in the bank registers alongside
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_hit1  <= 1'b0;
            s1_hit2  <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;               // Bubble when nothing offered
            s1_hit1  <= hit1;
            s1_hit2  <= hit2;
        end
    end

    // Transparency test on the raw byte
    assign opaque1 = s1_hit1 && (fetch1.pixel.raw != TRANSPARENT_KEY);
    assign opaque2 = s1_hit2 && (fetch2.pixel.raw != TRANSPARENT_KEY);

    // Stage 2, priority compose
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid     <= 1'b0;
            s2_visible   <= 1'b0;
            s2_color.raw <= BACKGROUND_COLOR;
        end else if (advance) begin
            s2_valid <= s1_valid;
            if (s1_valid) begin                 // Bubbles keep the old payload
                if (opaque2) begin
                    s2_color   <= fetch2.pixel; // Fighter 2 in front
                    s2_visible <= 1'b1;
                end else if (opaque1) begin
                    s2_color   <= fetch1.pixel;
                    s2_visible <= 1'b1;
                end else begin
                    s2_color.raw <= BACKGROUND_COLOR;
                    s2_visible   <= 1'b0;
                end
            end
        end
    end

    assign out_valid   = s2_valid;
    assign out_visible = s2_visible;
    assign out_color   = s2_color;

endmodule

`default_nettype wire

// ==== sprite_rom_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

// All poses of one fighter in a single synchronous ROM
module sprite_rom_bank #(
    parameter int PLAYER = 0                    // 0 first fighter, 1 second fighter
) (
    input  logic        clk,
    sprite_fetch_if.rom fetch
);
    import sprite_pkg::*;

    pixel_t                   mem [ROM_DEPTH];  // Pose-major sprite store
    logic [POSE_W+ADDR_W-1:0] rd_index;         // Pose * 256 + addr
    logic                     pose_ok;          // Pose code maps to a stored pose

    // Fill from the art rule at elaboration
    initial begin
        for (int p = 0; p < POSE_COUNT; p++) begin
            for (int r = 0; r < SPRITE_H; r++) begin
                for (int c = 0; c < SPRITE_W; c++) begin
                    mem[p * SPRITE_PIXELS + r * SPRITE_W + c].raw =
                        sprite_art_pixel(1'(PLAYER), POSE_W'(p),
                                         (ADDR_W/2)'(r), (ADDR_W/2)'(c));
                end
            end
        end
    end

    assign rd_index = {fetch.pose, fetch.addr};  // Concatenation is the multiply by 256
    assign pose_ok  = (fetch.pose <= POSE_BLOCK); // Codes 11..15 unused

    // One-cycle registered read
    always_ff @(posedge clk) begin
        if (fetch.en) begin
            if (pose_ok) begin
                fetch.pixel <= mem[rd_index];
            end else begin
                fetch.pixel.raw <= TRANSPARENT_KEY; // Unknown pose draws nothing
            end
        end
    end

endmodule

`default_nettype wire

// ==== sprite_fetch_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Read port between the compositor and one sprite ROM bank
interface sprite_fetch_if;
    import sprite_pkg::*;

    logic              en;      // Read strobe, pixel updates one edge later
    logic [POSE_W-1:0] pose;    // Pose select, 11 and up read as key
    logic [ADDR_W-1:0] addr;    // Row * 16 + column inside the pose
    pixel_t            pixel;   // Registered read data, holds while en is low

    // ROM side
    modport rom (
        input  en,
        input  pose,
        input  addr,
        output pixel
    );

    // Compositor side
    modport client (
        output en,
        output pose,
        output addr,
        input  pixel
    );

endinterface

`default_nettype wire

// ==== sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

    // Sprite geometry
    localparam int SPRITE_W      = 16;                        // Sprite width in pixels
    localparam int SPRITE_H      = 16;                        // Sprite height in pixels
    localparam int SPRITE_PIXELS = SPRITE_W * SPRITE_H;       // Words per pose
    localparam int POSE_COUNT    = 11;                        // Poses per fighter
    localparam int ROM_DEPTH     = POSE_COUNT * SPRITE_PIXELS; // Words per bank
    localparam int ADDR_W        = 8;                         // Address inside one pose
    localparam int POSE_W        = 4;                         // Pose code width
    localparam int COORD_W       = 10;                        // Raster coordinate width

    // Pose codes, shared with the game FSMs
    localparam logic [POSE_W-1:0] POSE_IDLE         = 4'd0;
    localparam logic [POSE_W-1:0] POSE_WALK         = 4'd1;
    localparam logic [POSE_W-1:0] POSE_WALKBACK     = 4'd2;
    localparam logic [POSE_W-1:0] POSE_ATTACK_START = 4'd3;
    localparam logic [POSE_W-1:0] POSE_ATTACK_END   = 4'd4;
    localparam logic [POSE_W-1:0] POSE_ATTACK_PULL  = 4'd5;
    localparam logic [POSE_W-1:0] POSE_DIRATT_START = 4'd6;
    localparam logic [POSE_W-1:0] POSE_DIRATT_END   = 4'd7;
    localparam logic [POSE_W-1:0] POSE_DIRATT_PULL  = 4'd8;
    localparam logic [POSE_W-1:0] POSE_GOT_HIT      = 4'd9;
    localparam logic [POSE_W-1:0] POSE_BLOCK        = 4'd10; // Last valid pose

    // RGB332 colours
    localparam logic [7:0] TRANSPARENT_KEY  = 8'hE3; // Magenta-ish key, never drawn
    localparam logic [7:0] BACKGROUND_COLOR = 8'h3B; // Shown where no sprite is opaque

    // One RGB332 word, seen as a byte or as colour fields
    typedef union packed {
        logic [7:0] raw;            // Whole byte, used for the key compare
        struct packed {
            logic [2:0] red;        // Bits 7:5
            logic [2:0] green;      // Bits 4:2
            logic [1:0] blue;       // Bits 1:0
        } rgb;
    } pixel_t;

    // Procedural sprite art, stands in for image data
    // Diagonal stripes of key give every pose visible holes.
    // An opaque pixel only equals the key for pose 12, which does not exist.
    function automatic logic [7:0] sprite_art_pixel(
        input logic                  player,
        input logic [POSE_W-1:0]     pose,
        input logic [ADDR_W/2-1:0]   row,
        input logic [ADDR_W/2-1:0]   col
    );
        if (row[1:0] == col[1:0]) begin
            return TRANSPARENT_KEY;                 // Diagonal hole
        end
        return {player, pose, col[2:0]};            // Player, pose, column tint
    endfunction

endpackage

`default_nettype wire
